/* stall_consts.svh */
/*
 * Stall-injection bridge constants
 * Bus widths, FIFO depth, debug register map and LFSR seeds
 */
`ifndef STALL_CONSTS_SVH
`define STALL_CONSTS_SVH

// Data and address width of the load/store port
`define STALL_DW          32
// Width of every stall count
`define STALL_CNT_W       8
// Outstanding transfers allowed, power of two
`define STALL_FIFO_DEPTH  4

// Debug register map
`define STALL_REG_MODE    2'd0
`define STALL_REG_MAX     2'd1
`define STALL_REG_GNT     2'd2
`define STALL_REG_VALID   2'd3

// LFSR start values, must be nonzero
`define STALL_GNT_SEED    16'hb5c3
`define STALL_VLD_SEED    16'h4e2d

`endif

/* stall_pkg.sv */
/*
 * Stall-injection bridge types
 * Mode encoding plus request, response and configuration structs
 */
`default_nettype none

`include "stall_consts.svh"

package stall_pkg;

    ////////////////////
    // Stall mode
    ////////////////////

    // Encoding 3 is unused and acts like off
    typedef enum logic [1:0] {
        STALL_OFF      = 2'd0,
        STALL_STANDARD = 2'd1,
        STALL_RANDOM   = 2'd2
    } stall_mode_e;

    ////////////////////
    // Port payloads
    ////////////////////

    // Request fields, same layout on core and memory side
    typedef struct packed {
        logic [`STALL_DW-1:0]   addr;
        logic [`STALL_DW-1:0]   wdata;
        logic                   we;
        logic [`STALL_DW/8-1:0] be;
    } core_req_t;

    // Read data returned with rvalid
    typedef struct packed {
        logic [`STALL_DW-1:0] rdata;
    } mem_rsp_t;

    ////////////////////
    // Configuration
    ////////////////////

    // Max applies in random mode, gnt/valid counts in standard mode
    typedef struct packed {
        stall_mode_e            mode;
        logic [`STALL_CNT_W-1:0] max_stall;
        logic [`STALL_CNT_W-1:0] gnt_stall;
        logic [`STALL_CNT_W-1:0] valid_stall;
    } stall_cfg_t;

endpackage

`default_nettype wire

/* stall_cfg_regs.sv */
/*
 * Stall configuration registers
 * Mode and stall counts, written through the debug port
 */
`default_nettype none

`include "stall_consts.svh"

module stall_cfg_regs
    import stall_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,

    // Debug write port
    input  logic                 dbg_req_i,
    input  logic                 dbg_we_i,
    input  logic [1:0]           dbg_addr_i,
    input  logic [`STALL_DW-1:0] dbg_wdata_i,

    // Current configuration to both paths
    output stall_cfg_t           cfg_o
);

    stall_cfg_t cfg_q;
    logic       wr_en;

    // Reads are not supported, only writes change state
    assign wr_en = dbg_req_i && dbg_we_i;

    ////////////////////
    // Register write
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // Off mode, all counts zero
            cfg_q.mode        <= STALL_OFF;
            cfg_q.max_stall   <= '0;
            cfg_q.gnt_stall   <= '0;
            cfg_q.valid_stall <= '0;
        end else if (wr_en) begin
            // Low bits of write data go to the addressed field
            case (dbg_addr_i)
                `STALL_REG_MODE: begin
                    cfg_q.mode <= stall_mode_e'(dbg_wdata_i[1:0]);
                end
                `STALL_REG_MAX: begin
                    cfg_q.max_stall <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
                `STALL_REG_GNT: begin
                    cfg_q.gnt_stall <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
                `STALL_REG_VALID: begin
                    cfg_q.valid_stall <= dbg_wdata_i[`STALL_CNT_W-1:0];
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* stall_delay_gen.sv */
/*
 * Stall delay generator
 * Loads a fixed or LFSR-derived count on start and counts it down
 */
`default_nettype none

`include "stall_consts.svh"

module stall_delay_gen
    import stall_pkg::*;
#(
    parameter logic [15:0] SEED = 16'hace1
) (
    input  logic                    clk_i,
    input  logic                    rst_i,

    // One-cycle pulse, loads a new count at the next edge
    input  logic                    start_i,

    input  stall_mode_e             mode_i,
    input  logic [`STALL_CNT_W-1:0] max_i,
    input  logic [`STALL_CNT_W-1:0] fixed_i,

    // High while idle at zero and no load is pending
    output logic                    done_o
);

    localparam int CW = `STALL_CNT_W;

    logic [15:0]   lfsr_q;
    logic          lfsr_fb;
    logic [15:0]   rnd_span;
    logic [15:0]   rnd_val;
    logic [CW-1:0] load_val;
    logic [CW-1:0] cnt_q;

    ////////////////////
    // Random source
    ////////////////////

    // Fibonacci LFSR, taps 16 14 13 11, maximal length
    assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // Free running, so the drawn value depends on start timing too
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfsr_q <= SEED;
        end else begin
            lfsr_q <= {lfsr_q[14:0], lfsr_fb};
        end
    end

    // Range 0 to max inclusive
    assign rnd_span = 16'(max_i) + 16'd1;
    assign rnd_val  = lfsr_q % rnd_span;

    ////////////////////
    // Count selection
    ////////////////////

    always_comb begin
        case (mode_i)
            STALL_STANDARD: load_val = fixed_i;
            STALL_RANDOM:   load_val = rnd_val[CW-1:0];
            // Off and the spare encoding, no stall
            default:        load_val = '0;
        endcase
    end

    ////////////////////
    // Down counter
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= load_val;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // A load of N gives done again N cycles after the loading edge
    assign done_o = (cnt_q == '0) && !start_i;

endmodule

`default_nettype wire

/* stall_req_path.sv */
/*
 * Request path of the stall bridge
 * Delays the core grant, limits outstanding transfers and queues
 * granted requests toward memory
 */
`default_nettype none

`include "stall_consts.svh"

module stall_req_path
    import stall_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // Core side
    input  logic       core_req_i,
    input  core_req_t  core_data_i,
    output logic       core_gnt_o,

    // Memory side
    output logic       mem_req_o,
    output core_req_t  mem_data_o,
    input  logic       mem_gnt_i,

    // One pulse per response handed back to the core
    input  logic       rsp_done_i,

    input  stall_cfg_t cfg_i
);

    localparam int DEPTH = `STALL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef enum logic {
        REQ_IDLE,
        REQ_STALL
    } req_state_e;

    req_state_e       state_q, state_d;
    core_req_t        fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] fifo_cnt_q;
    logic [CNT_W-1:0] outst_q;
    logic             fifo_full, fifo_empty, has_room;
    logic             stall_start, stall_done;
    logic             push, pop;

    assign fifo_full  = fifo_cnt_q == CNT_W'(DEPTH);
    assign fifo_empty = fifo_cnt_q == '0;
    // Outstanding count also covers entries still in the FIFO
    assign has_room   = !fifo_full && (outst_q < CNT_W'(DEPTH));

    ////////////////////
    // Grant FSM
    ////////////////////

    always_comb begin
        state_d     = state_q;
        stall_start = 1'b0;
        core_gnt_o  = 1'b0;
        case (state_q)
            REQ_IDLE: begin
                // Request only counts as seen once there is room
                if (core_req_i && has_room) begin
                    stall_start = 1'b1;
                    state_d     = REQ_STALL;
                end
            end
            REQ_STALL: begin
                if (stall_done) begin
                    core_gnt_o = 1'b1;
                    state_d    = REQ_IDLE;
                end
            end
            default: state_d = REQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= REQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    stall_delay_gen #(
        .SEED    (`STALL_GNT_SEED)
    ) gnt_delay_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (stall_start),
        .mode_i  (cfg_i.mode),
        .max_i   (cfg_i.max_stall),
        .fixed_i (cfg_i.gnt_stall),
        .done_o  (stall_done)
    );

    ////////////////////
    // Outstanding count
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outst_q <= '0;
        end else begin
            case ({core_gnt_o, rsp_done_i})
                2'b10:   outst_q <= outst_q + 1'b1;
                2'b01:   outst_q <= outst_q - 1'b1;
                default: outst_q <= outst_q;
            endcase
        end
    end

    ////////////////////
    // Request FIFO
    ////////////////////

    // Granted request enters in the grant cycle
    assign push = core_gnt_o;
    assign pop  = mem_req_o && mem_gnt_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= core_data_i;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fifo_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
                2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
                default: fifo_cnt_q <= fifo_cnt_q;
            endcase
        end
    end

    // Head stays on the bus until memory grants it
    assign mem_req_o  = !fifo_empty;
    assign mem_data_o = fifo_mem[rd_ptr_q];

endmodule

`default_nettype wire

/* stall_resp_path.sv */
/*
 * Response path of the stall bridge
 * Buffers memory responses and releases each one to the core after
 * its valid stall
 */
`default_nettype none

`include "stall_consts.svh"

module stall_resp_path
    import stall_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // Memory side, never back-pressured
    input  logic       mem_rvalid_i,
    input  mem_rsp_t   mem_rsp_i,

    // Core side
    output logic       core_rvalid_o,
    output mem_rsp_t   core_rsp_o,

    // Pulse per released response, frees one outstanding slot
    output logic       rsp_done_o,

    input  stall_cfg_t cfg_i
);

    localparam int DEPTH = `STALL_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_rsp_t         fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] fifo_cnt_q;
    logic             head_armed_q;
    logic             fifo_empty;
    logic             stall_start, stall_done;
    logic             push, pop;

    ////////////////////
    // Response FIFO
    ////////////////////

    // Outstanding limit upstream keeps this from overflowing
    assign push       = mem_rvalid_i;
    assign fifo_empty = fifo_cnt_q == '0;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= mem_rsp_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            fifo_cnt_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
                2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
                default: fifo_cnt_q <= fifo_cnt_q;
            endcase
        end
    end

    ////////////////////
    // Release control
    ////////////////////

    // New head present and no stall running for it yet
    assign stall_start = !fifo_empty && !head_armed_q;

    // Armed from the start pulse until the entry is popped
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_armed_q <= 1'b0;
        end else if (pop) begin
            head_armed_q <= 1'b0;
        end else if (stall_start) begin
            head_armed_q <= 1'b1;
        end
    end

    stall_delay_gen #(
        .SEED    (`STALL_VLD_SEED)
    ) vld_delay_i (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (stall_start),
        .mode_i  (cfg_i.mode),
        .max_i   (cfg_i.max_stall),
        .fixed_i (cfg_i.valid_stall),
        .done_o  (stall_done)
    );

    // Single-cycle rvalid, head popped in the same cycle
    assign core_rvalid_o = head_armed_q && stall_done;
    assign core_rsp_o    = fifo_mem[rd_ptr_q];
    assign pop           = core_rvalid_o;
    assign rsp_done_o    = core_rvalid_o;

endmodule

`default_nettype wire

/* random_stall_unit.sv */
/*
 * Stall-injection bridge top
 * Sits between the core load/store port and data memory
 */
`default_nettype none

`include "stall_consts.svh"

module random_stall_unit
    import stall_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_i,

    ////////////////////
    // Core side
    ////////////////////
    input  logic                 core_req_i,
    input  core_req_t            core_data_i,
    output logic                 core_gnt_o,
    output logic                 core_rvalid_o,
    output mem_rsp_t             core_rsp_o,

    ////////////////////
    // Memory side
    ////////////////////
    output logic                 mem_req_o,
    output core_req_t            mem_data_o,
    input  logic                 mem_gnt_i,
    input  logic                 mem_rvalid_i,
    input  mem_rsp_t             mem_rsp_i,

    ////////////////////
    // Debug write port
    ////////////////////
    input  logic                 dbg_req_i,
    input  logic                 dbg_we_i,
    input  logic [1:0]           dbg_addr_i,
    input  logic [`STALL_DW-1:0] dbg_wdata_i
);

    stall_cfg_t cfg;
    // Response release back to the outstanding counter
    logic       rsp_done;

    stall_cfg_regs cfg_regs_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dbg_req_i   (dbg_req_i),
        .dbg_we_i    (dbg_we_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_wdata_i (dbg_wdata_i),
        .cfg_o       (cfg)
    );

    // Grant side stall and request queue
    stall_req_path req_path_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .core_req_i  (core_req_i),
        .core_data_i (core_data_i),
        .core_gnt_o  (core_gnt_o),
        .mem_req_o   (mem_req_o),
        .mem_data_o  (mem_data_o),
        .mem_gnt_i   (mem_gnt_i),
        .rsp_done_i  (rsp_done),
        .cfg_i       (cfg)
    );

    // Valid side stall and response queue
    stall_resp_path resp_path_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_rvalid_i  (mem_rvalid_i),
        .mem_rsp_i     (mem_rsp_i),
        .core_rvalid_o (core_rvalid_o),
        .core_rsp_o    (core_rsp_o),
        .rsp_done_o    (rsp_done),
        .cfg_i         (cfg)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
/*
 * Testbench data memory
 * Random grant and rvalid timing, byte-enable writes, in-order responses
 */
`default_nettype none

`include "stall_consts.svh"

module tb_mem_model
    import stall_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       mem_req_i,
    input  core_req_t  mem_data_i,
    // Wait cycles before a grant and before each response
    input  logic [3:0] gnt_dly_i,
    input  logic [7:0] rvalid_dly_i,
    output logic       mem_gnt_o,
    output logic       mem_rvalid_o,
    output mem_rsp_t   mem_rsp_o
);

    logic [31:0] mem [64];
    int          mcyc;
    int          wait_cnt;
    int          due_q[$];
    logic [31:0] dat_q[$];

    // Fill word derived from the full byte address of the word
    initial begin
        mem_gnt_o    = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rsp_o    = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = (32'(i * 4) * 32'h9e3779b1) ^ 32'hc3a50f1e;
        end
    end

    // Outputs change on the falling edge and the bridge samples on the rising one
    always @(negedge clk_i) begin : drive
        logic [5:0] idx;
        if (rst_i) begin
            mem_gnt_o    = 1'b0;
            mem_rvalid_o = 1'b0;
            mem_rsp_o    = '0;
            mcyc         = 0;
            wait_cnt     = 0;
            due_q.delete();
            dat_q.delete();
        end else begin
            mcyc++;
            // Grant lasts one cycle and the bridge pops its head on it
            if (mem_gnt_o) begin
                mem_gnt_o = 1'b0;
            end else if (mem_req_i) begin
                if (wait_cnt >= int'(gnt_dly_i)) begin
                    mem_gnt_o = 1'b1;
                    wait_cnt  = 0;
                    idx       = mem_data_i.addr[7:2];
                    if (mem_data_i.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_data_i.be[b]) begin
                                mem[idx][8*b +: 8] = mem_data_i.wdata[8*b +: 8];
                            end
                        end
                        dat_q.push_back(32'd0);
                    end else begin
                        dat_q.push_back(mem[idx]);
                    end
                    // Earliest response in the cycle after the grant
                    due_q.push_back(mcyc + 1 + int'(rvalid_dly_i));
                end else begin
                    wait_cnt++;
                end
            end
            // Responses leave strictly in grant order
            mem_rvalid_o = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= mcyc) begin
                mem_rvalid_o    = 1'b1;
                mem_rsp_o.rdata = dat_q.pop_front();
                void'(due_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* tb_random_stall.sv */
/*
 * Testbench for the stall-injection bridge
 * Drives the core and debug ports, models memory, checks data and stall timing
 */
`default_nettype none

`include "stall_consts.svh"

module tb_random_stall
    import stall_pkg::*;
();

    localparam int    NUM_XFER   = 50;
    // Worst transfer: two stalls of at most 8, memory waits up to 15 and 40
    localparam int    WORST_CYC  = 2 * (8 + 2) + 15 + 40;
    localparam longint WATCHDOG_T = longint'(16 + 40 + NUM_XFER * WORST_CYC) * 100;

    logic        clk_i = 1'b0;
    logic        rst_i;
    logic        core_req;
    core_req_t   core_data;
    logic        core_gnt, core_rvalid;
    mem_rsp_t    core_rsp;
    logic        mem_req, mem_gnt, mem_rvalid;
    core_req_t   mem_data;
    mem_rsp_t    mem_rsp;
    logic        dbg_req, dbg_we;
    logic [1:0]  dbg_addr;
    logic [31:0] dbg_wdata;
    logic [3:0]  mem_gnt_dly;
    logic [7:0]  mem_rvalid_dly;

    logic [31:0] lfsr_q = 32'h1daa4672;
    logic [31:0] shadow [64];
    core_req_t   fwd_q[$];
    mem_rsp_t    rsp_q[$];
    int          push_q[$];
    int          cyc, n_gnt, n_rsp, err_cnt, chk_cnt, test_err;
    int          seen_cyc, freed_cyc, max_outst;
    bit          seen_vld, freed_pend;
    // Stall checks enabled by the running test, with their bounds
    bit          gnt_chk, vld_chk, lim_chk;
    int          gnt_lo, gnt_hi, vld_lo, vld_hi;

    always #50 clk_i = ~clk_i;

    random_stall_unit random_stall_unit_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .core_req_i    (core_req),
        .core_data_i   (core_data),
        .core_gnt_o    (core_gnt),
        .core_rvalid_o (core_rvalid),
        .core_rsp_o    (core_rsp),
        .mem_req_o     (mem_req),
        .mem_data_o    (mem_data),
        .mem_gnt_i     (mem_gnt),
        .mem_rvalid_i  (mem_rvalid),
        .mem_rsp_i     (mem_rsp),
        .dbg_req_i     (dbg_req),
        .dbg_we_i      (dbg_we),
        .dbg_addr_i    (dbg_addr),
        .dbg_wdata_i   (dbg_wdata)
    );

    tb_mem_model mem_model_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_req_i    (mem_req),
        .mem_data_i   (mem_data),
        .gnt_dly_i    (mem_gnt_dly),
        .rvalid_dly_i (mem_rvalid_dly),
        .mem_gnt_o    (mem_gnt),
        .mem_rvalid_o (mem_rvalid),
        .mem_rsp_o    (mem_rsp)
    );

    ////////////////////
    // Random source and reference
    ////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // Expected read data from the shadow memory
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[addr[7:2]];
    endfunction

    // Writes land only in enabled byte lanes
    function automatic void apply_write(input core_req_t req);
        for (int b = 0; b < 4; b++) begin
            if (req.be[b]) begin
                shadow[req.addr[7:2]][8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("Mismatch at %0t: rdata got %h expected %h", $time, got.rdata, exp.rdata);
            err_cnt++;
        end
    endtask

    task automatic check_req(input core_req_t got, input core_req_t exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("Mismatch at %0t: forwarded addr %h wdata %h we %b be %h, expected %h %h %b %h",
                     $time, got.addr, got.wdata, got.we, got.be,
                     exp.addr, exp.wdata, exp.we, exp.be);
            err_cnt++;
        end
    endtask

    task automatic check_stall(input string what, input int got, input int lo, input int hi);
        chk_cnt++;
        if (got < lo || got > hi) begin
            $display("Mismatch at %0t: %s delay %0d outside %0d..%0d", $time, what, got, lo, hi);
            err_cnt++;
        end
    endtask

    ////////////////////
    // Monitor
    ////////////////////

    // Reads pre-edge values, all DUT state updates are nonblocking
    always @(posedge clk_i) begin : monitor
        int        outst;
        mem_rsp_t  exp_rsp;
        if (!rst_i) begin
            cyc++;
            outst = n_gnt - n_rsp;
            if (outst > max_outst) begin
                max_outst = outst;
            end
            if (!lim_chk) begin
                freed_pend = 1'b0;
            end
            if (core_gnt) begin
                if (outst >= `STALL_FIFO_DEPTH) begin
                    $display("Grant issued at %0t with %0d transfers outstanding", $time, outst);
                    err_cnt++;
                end
                if (gnt_chk) begin
                    check_stall("grant", cyc - seen_cyc, gnt_lo, gnt_hi);
                end
                if (freed_pend) begin
                    // Slot freed by rsp_done, request seen next edge, grant one later
                    check_stall("refill", cyc - freed_cyc, 2, 2);
                    freed_pend = 1'b0;
                end
                fwd_q.push_back(core_data);
                if (core_data.we) begin
                    apply_write(core_data);
                    exp_rsp.rdata = '0;
                end else begin
                    exp_rsp.rdata = ref_read(core_data.addr);
                end
                rsp_q.push_back(exp_rsp);
                n_gnt++;
                seen_vld = 1'b0;
            end else if (core_req && !seen_vld) begin
                seen_vld = 1'b1;
                seen_cyc = cyc;
            end
            if (mem_req && mem_gnt) begin
                if (fwd_q.size() == 0) begin
                    $display("Memory request at %0t without a granted core request", $time);
                    err_cnt++;
                end else begin
                    check_req(mem_data, fwd_q.pop_front());
                end
            end
            // Release of the older head comes before this edge's push
            if (core_rvalid) begin
                if (rsp_q.size() == 0) begin
                    $display("Response at %0t with no transfer outstanding", $time);
                    err_cnt++;
                end else begin
                    check_rsp(core_rsp, rsp_q.pop_front());
                end
                // Head is seen one edge after its push, release N+1 after that
                if (push_q.size() > 0) begin
                    if (vld_chk) begin
                        check_stall("valid", cyc - push_q[0], vld_lo, vld_hi);
                    end
                    void'(push_q.pop_front());
                end
                if (lim_chk && outst == `STALL_FIFO_DEPTH) begin
                    freed_pend = 1'b1;
                    freed_cyc  = cyc;
                end
                n_rsp++;
            end
            if (mem_rvalid) begin
                push_q.push_back(cyc);
            end
        end
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data, input logic we);
        @(negedge clk_i);
        dbg_req   = 1'b1;
        dbg_we    = we;
        dbg_addr  = addr;
        dbg_wdata = data;
        @(negedge clk_i);
        dbg_req = 1'b0;
        dbg_we  = 1'b0;
    endtask

    // Request held from a falling edge until the edge that samples the grant
    task automatic issue_rand();
        logic [31:0] r;
        @(negedge clk_i);
        r = rand_bits(6);
        core_data.addr  = {24'd0, r[5:0], 2'b00};
        core_data.wdata = rand_bits(32);
        r = rand_bits(5);
        core_data.we    = r[4];
        core_data.be    = (r[3:0] == 4'h0) ? 4'hf : r[3:0];
        core_req        = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!core_gnt);
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        core_req = 1'b0;
        while (n_gnt != n_rsp) begin
            @(negedge clk_i);
        end
    endtask

    task automatic run_seq(input int n, input bit rand_mem);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            if (rand_mem) begin
                r = rand_bits(6);
                mem_gnt_dly    = {2'b00, r[1:0]};
                mem_rvalid_dly = {4'd0, r[5:2]};
            end
            issue_rand();
            wait_idle();
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %-10s finished, %0d errors", name, err_cnt - test_err);
        test_err = err_cnt;
        gnt_chk  = 1'b0;
        vld_chk  = 1'b0;
        lim_chk  = 1'b0;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : main
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = (32'(i * 4) * 32'h9e3779b1) ^ 32'hc3a50f1e;
        end
        rst_i = 1'b1;
        core_req = 1'b0;
        core_data = '0;
        dbg_req = 1'b0;
        dbg_we = 1'b0;
        dbg_addr = 2'd0;
        dbg_wdata = '0;
        mem_gnt_dly = 4'd0;
        mem_rvalid_dly = 8'd0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Off mode, back-to-back transfers
        r = rand_bits(5);
        mem_gnt_dly    = {2'b00, r[1:0]};
        mem_rvalid_dly = {5'd0, r[4:2]};
        for (int i = 0; i < 12; i++) begin
            issue_rand();
        end
        wait_idle();
        end_test("off");

        // Standard mode, exact stall counts
        write_reg(`STALL_REG_GNT, 32'd3, 1'b1);
        write_reg(`STALL_REG_VALID, 32'd5, 1'b1);
        write_reg(`STALL_REG_MODE, 32'(STALL_STANDARD), 1'b1);
        gnt_chk = 1'b1;
        {gnt_lo, gnt_hi} = {32'd4, 32'd4};
        vld_chk = 1'b1;
        {vld_lo, vld_hi} = {32'd7, 32'd7};
        run_seq(6, 1'b1);
        end_test("standard");

        // Random mode, stalls bounded by the maximum
        write_reg(`STALL_REG_MAX, 32'd7, 1'b1);
        write_reg(`STALL_REG_MODE, 32'(STALL_RANDOM), 1'b1);
        gnt_chk = 1'b1;
        {gnt_lo, gnt_hi} = {32'd1, 32'd8};
        vld_chk = 1'b1;
        {vld_lo, vld_hi} = {32'd2, 32'd9};
        run_seq(12, 1'b1);
        end_test("random");

        // Outstanding limit, slow memory responses
        write_reg(`STALL_REG_MODE, 32'(STALL_OFF), 1'b1);
        mem_gnt_dly    = 4'd0;
        mem_rvalid_dly = 8'd40;
        max_outst      = 0;
        lim_chk        = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue_rand();
        end
        wait_idle();
        check_stall("outstanding depth", max_outst, `STALL_FIFO_DEPTH, `STALL_FIFO_DEPTH);
        end_test("limit");

        // Debug access without write enable, then mode change between transfers
        mem_rvalid_dly = 8'd2;
        write_reg(`STALL_REG_GNT, 32'd3, 1'b1);
        write_reg(`STALL_REG_VALID, 32'd0, 1'b1);
        write_reg(`STALL_REG_MODE, 32'(STALL_STANDARD), 1'b1);
        write_reg(`STALL_REG_GNT, 32'd9, 1'b0);
        gnt_chk = 1'b1;
        {gnt_lo, gnt_hi} = {32'd4, 32'd4};
        vld_chk = 1'b1;
        {vld_lo, vld_hi} = {32'd2, 32'd2};
        run_seq(2, 1'b0);
        write_reg(`STALL_REG_MODE, 32'(STALL_OFF), 1'b1);
        {gnt_lo, gnt_hi} = {32'd1, 32'd1};
        run_seq(2, 1'b0);
        end_test("registers");

        if (rsp_q.size() != 0 || fwd_q.size() != 0) begin
            $display("Transfers left unfinished at the end of the run");
            err_cnt++;
        end
        $display("Summary: %0d transfers, %0d checks, %0d errors", n_gnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from transfer count and worst-case stall
    initial begin : watchdog
        #(WATCHDOG_T);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_T);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
stall_pkg.sv
stall_cfg_regs.sv
stall_delay_gen.sv
stall_req_path.sv
stall_resp_path.sv
random_stall_unit.sv
tb_mem_model.sv
tb_random_stall.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat filelist.f)) stall_consts.svh

.PHONY: all run check clean

all: obj_dir/Vtb_random_stall

obj_dir/Vtb_random_stall: filelist.f $(SRCS)
	verilator --binary --top-module tb_random_stall -f filelist.f -Mdir obj_dir

sim.log: obj_dir/Vtb_random_stall
	./obj_dir/Vtb_random_stall > sim.log; cat sim.log

run: sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "Simulation did not finish"; exit 1; fi

check: run

clean:
	rm -rf obj_dir sim.log
